/* rtl/noc_config.svh */
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// flit payload width
`define FLIT_DATA_W 32

// packet length field, also sets the hold timer width
`define LEN_W 12

// flit kind field
`define FLIT_ID_W 3

`endif

/* rtl/noc_pkg.sv */
`default_nettype none

`include "noc_config.svh"

package noc_pkg;

  // the five inputs, listed in rotation order
  typedef enum logic [2:0] {
    LOCAL = 3'd0,
    NORTH = 3'd1,
    EAST  = 3'd2,
    WEST  = 3'd3,
    SOUTH = 3'd4
  } portIdx;

  // one-hot states, bits 5:1 are the grant lines in portIdx order
  typedef enum logic [5:0] {
    IDLE  = 6'b000001,
    GNT_L = 6'b000010,
    GNT_N = 6'b000100,
    GNT_E = 6'b001000,
    GNT_W = 6'b010000,
    GNT_S = 6'b100000
  } arbState;

  typedef enum logic [`FLIT_ID_W-1:0] {
    NONE, // empty slot
    HEAD, // carries packet length
    BODY,
    TAIL
  } flitKind;

endpackage

`default_nettype wire

/* rtl/flitLink_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

interface flitLink_if;
  import noc_pkg::*;

  logic req; // level, held while flits wait
  flitKind kind;
  logic [`LEN_W-1:0] length; // meaningful on HEAD only
  logic [`FLIT_DATA_W-1:0] data;

  modport source (
    output req,
    output kind,
    output length,
    output data
  );

  modport sink (
    input req,
    input kind,
    input length,
    input data
  );

endinterface

`default_nettype wire

/* rtl/packetTimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module packetTimer (
  input  logic clk,
  input  logic rst,
  input  noc_pkg::flitKind kind,
  input  logic [`LEN_W-1:0] length,
  input  logic run,
  output logic expired
);
  import noc_pkg::*;

  logic [`LEN_W-1:0] timeout; // hold limit from last header
  logic [`LEN_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeout <= '0;
      count <= '0;
    end
    else
    begin
      // any header seen on the link refreshes the limit, granted or not
      if (kind == HEAD)
        timeout <= length;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0; // idle or lost the port
    end
  end

  // holder keeps the port for timeout+1 cycles
  assign expired = (count == timeout);

endmodule

`default_nettype wire

/* rtl/outputArbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module outputArbiter (
  input  logic clk,
  input  logic rst,
  flitLink_if.sink links [5],
  output logic [4:0] grant,
  output noc_pkg::arbState state
);
  import noc_pkg::*;

  logic [4:0] linkReq;
  flitKind linkKind [5];
  logic [`LEN_W-1:0] linkLen [5];

  logic [4:0] run;
  logic [4:0] expired;

  arbState nextState;
  portIdx holder;
  logic held; // some port owns the output
  logic keep;

  // first requester in rotation order, beginning at index start
  function automatic arbState firstReq(input logic [4:0] r, input int unsigned start);
    arbState pick;
    int unsigned idx;
    logic found;
    pick = IDLE;
    found = 1'b0;
    for (int k = 0; k < 5; k++)
    begin
      idx = (start + k) % 5;
      if (!found && r[idx])
      begin
        pick = arbState'(6'b000010 << idx);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  genvar i;
  generate
    for (i = 0; i < 5; i++)
    begin : g_port
      assign linkReq[i] = links[i].req;
      assign linkKind[i] = links[i].kind;
      assign linkLen[i] = links[i].length;

      packetTimer timer (
        .clk(clk),
        .rst(rst),
        .kind(linkKind[i]),
        .length(linkLen[i]),
        .run(run[i]),
        .expired(expired[i])
      );
    end
  endgenerate

  // decode the holder from the one-hot state
  always_comb
  begin
    holder = LOCAL;
    held = 1'b1;
    case (state)
      GNT_L: holder = LOCAL;
      GNT_N: holder = NORTH;
      GNT_E: holder = EAST;
      GNT_W: holder = WEST;
      GNT_S: holder = SOUTH;
      default: held = 1'b0; // IDLE or corrupt state
    endcase
  end

  assign keep = held && linkReq[holder] && !expired[holder];

  always_comb
  begin
    run = '0;
    if (!held)
      nextState = firstReq(linkReq, 0); // plain priority L..S
    else if (keep)
    begin
      nextState = state;
      run[holder] = 1'b1; // only a kept cycle counts
    end
    else
    begin
      // holder masked so it can't win its own rotation
      nextState = firstReq(linkReq & ~(5'b00001 << holder), int'(holder) + 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= nextState;
  end

  assign grant = state[5:1];

endmodule

`default_nettype wire

/* rtl/outputMux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module outputMux (
  input  logic clk,
  input  logic rst,
  flitLink_if.sink links [5],
  input  logic [4:0] grant,
  output logic [`FLIT_DATA_W-1:0] outFlit,
  output noc_pkg::flitKind outKind,
  output logic outValid
);
  import noc_pkg::*;

  logic [4:0] linkReq;
  flitKind linkKind [5];
  logic [`FLIT_DATA_W-1:0] linkData [5];

  logic [`FLIT_DATA_W-1:0] selData;
  flitKind selKind;
  logic selReq;
  logic selValid;

  genvar i;
  generate
    for (i = 0; i < 5; i++)
    begin : g_link
      assign linkReq[i] = links[i].req;
      assign linkKind[i] = links[i].kind;
      assign linkData[i] = links[i].data;
    end
  endgenerate

  // grant is one-hot, so at most one branch fires
  always_comb
  begin
    selData = '0;
    selKind = NONE;
    selReq = 1'b0;
    for (int k = 0; k < 5; k++)
    begin
      if (grant[k])
      begin
        selData = linkData[k];
        selKind = linkKind[k];
        selReq = linkReq[k];
      end
    end
  end

  assign selValid = (|grant) && selReq;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outKind <= NONE;
    end
    else
    begin
      outValid <= selValid;
      outKind <= selValid ? selKind : NONE; // no kind on empty slots
    end
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selData; // payload, qualified by outValid
  end

endmodule

`default_nettype wire

/* rtl/routerOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module routerOutputPort (
  input  logic clk,
  input  logic rst,
  input  logic [4:0] req,
  input  noc_pkg::flitKind kind [5],
  input  logic [`LEN_W-1:0] length [5],
  input  logic [`FLIT_DATA_W-1:0] data [5],
  output logic [4:0] grant,
  output logic [`FLIT_DATA_W-1:0] outFlit,
  output noc_pkg::flitKind outKind,
  output logic outValid
);
  import noc_pkg::*;

  // one link per input in portIdx order
  flitLink_if link [5] ();

  genvar i;
  generate
    for (i = 0; i < 5; i++)
    begin : g_link
      assign link[i].req = req[i];
      assign link[i].kind = kind[i];
      assign link[i].length = length[i];
      assign link[i].data = data[i];
    end
  endgenerate

  outputArbiter arbiter (
    .clk(clk),
    .rst(rst),
    .links(link),
    .grant(grant),
    .state() // arbiter state stays internal
  );

  // flit follows its grant by one cycle
  outputMux mux (
    .clk(clk),
    .rst(rst),
    .links(link),
    .grant(grant),
    .outFlit(outFlit),
    .outKind(outKind),
    .outValid(outValid)
  );

endmodule

`default_nettype wire

/* verification/tb_routerOutputPort.sv */
`timescale 1ns/1ps
`default_nettype none

`include "noc_config.svh"

module tb_routerOutputPort;
  import noc_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int DIRECTED_CYCLES = 200; // loose bound for the directed part
  localparam int RANDOM_CYCLES = 4000;
  localparam int MARGIN_CYCLES = 500;
  localparam int WATCHDOG_NS =
    (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * 20;

  logic clk;
  logic rst;
  logic [4:0] req;
  flitKind kind [5];
  logic [`LEN_W-1:0] length [5];
  logic [`FLIT_DATA_W-1:0] data [5];
  logic [4:0] grant;
  logic [`FLIT_DATA_W-1:0] outFlit;
  flitKind outKind;
  logic outValid;

  string testName;

  int mHolder; // model holder or -1 when idle
  int mNext;
  logic mExpired;
  logic mKept;
  logic [`LEN_W-1:0] mTimeout [5];
  logic [`LEN_W-1:0] mCount [5];
  logic [4:0] expGrant;
  logic expValid;
  flitKind expKind;
  logic [`FLIT_DATA_W-1:0] expFlit;

  int srcLen [5];
  int srcPos [5]; // -1 between packets
  int srcGap [5];
  int srcSeq [5];
  logic [4:0] lastGrant;
  int holdCount;

  routerOutputPort i_dut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .kind(kind),
    .length(length),
    .data(data),
    .grant(grant),
    .outFlit(outFlit),
    .outKind(outKind),
    .outValid(outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // expected next holder or -1 for idle
  function automatic int refNextHolder(input int holder, input logic [4:0] r, input logic expired);
    int next;
    int p;
    next = -1;
    if (holder < 0)
    begin
      for (int k = 4; k >= 0; k--)
        if (r[k])
          next = k; // lowest index wins
    end
    else if (r[holder] && !expired)
      next = holder;
    else
    begin
      for (int k = 4; k >= 1; k--)
      begin
        p = (holder + k) % 5;
        if (r[p])
          next = p;
      end
    end
    return next;
  endfunction

  function automatic logic [`FLIT_DATA_W-1:0] makeWord(input int p, input int seq);
    return ((p & 8'hff) << 24) | (seq & 24'hffffff); // port in the top byte
  endfunction

  task automatic compareValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED test %s, %s: expected %0h actual %0h",
               testName, what, expected, actual);
      $display("tests failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic driveLink(input int p, input logic r, input flitKind k, input int len,
                           input int seq);
    req[p] = r;
    kind[p] = k;
    length[p] = `LEN_W'(len);
    data[p] = makeWord(p, seq);
  endtask

  task automatic idleAll();
    for (int p = 0; p < 5; p++)
      driveLink(p, 1'b0, NONE, 0, 0);
  endtask

  task automatic awaitGrant(input logic [4:0] want, input int maxCycles);
    int n;
    n = 0;
    while (grant !== want)
    begin
      if (n == maxCycles)
      begin
        $display("grant never reached %b within %0d cycles in test %s",
                 want, maxCycles, testName);
        $display("tests failed");
        $fatal(1, "grant wait timed out");
      end
      n++;
      @(negedge clk);
    end
  endtask

  // one packet source emitting HEAD, len BODY flits and TAIL before a short gap
  task automatic stepSource(input int p);
    flitKind k;
    if (srcPos[p] >= 0 && lastGrant[p] && req[p])
    begin
      srcSeq[p]++;
      if (srcPos[p] == srcLen[p] + 1)
      begin
        srcPos[p] = -1;
        srcGap[p] = $urandom % 4;
      end
      else
        srcPos[p]++;
    end
    if (srcPos[p] < 0)
    begin
      if (srcGap[p] == 0)
      begin
        srcLen[p] = $urandom % 8;
        srcPos[p] = 0;
      end
      else
        srcGap[p]--;
    end
    if (srcPos[p] < 0)
      driveLink(p, 1'b0, NONE, 0, srcSeq[p]);
    else
    begin
      k = (srcPos[p] == 0) ? HEAD : (srcPos[p] == srcLen[p] + 1) ? TAIL : BODY;
      driveLink(p, 1'b1, k, srcLen[p], srcSeq[p]);
    end
  endtask

  // reference model and compare on every rising edge
  always @(posedge clk)
  begin
    if (rst)
    begin
      mHolder = -1;
      for (int p = 0; p < 5; p++)
      begin
        mTimeout[p] = '0;
        mCount[p] = '0;
      end
      expGrant = '0;
      expValid = 1'b0;
      expKind = NONE;
    end
    else
    begin
      expValid = (mHolder >= 0) && req[mHolder];
      expKind = expValid ? kind[mHolder] : NONE;
      if (mHolder >= 0)
        expFlit = data[mHolder];
      mExpired = (mHolder >= 0) && (mCount[mHolder] == mTimeout[mHolder]);
      mNext = refNextHolder(mHolder, req, mExpired);
      mKept = (mHolder >= 0) && (mNext == mHolder);
      for (int p = 0; p < 5; p++)
      begin
        if (mKept && p == mHolder)
          mCount[p] = mCount[p] + 1'b1;
        else
          mCount[p] = '0;
        if (kind[p] == HEAD)
          mTimeout[p] = length[p]; // granted or not
      end
      mHolder = mNext;
      expGrant = (mHolder >= 0) ? (5'b00001 << mHolder) : 5'b00000;
    end
    #1;
    compareValue("grant one-hot", 1'b1, $onehot0(grant));
    compareValue("grant", expGrant, grant);
    compareValue("outValid", expValid, outValid);
    compareValue("outKind", expKind, outKind);
    if (expValid)
      compareValue("outFlit", expFlit, outFlit);
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog: simulation ran past its time limit, DUT seems stuck");
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    void'($urandom(24));
    testName = "reset";
    rst = 1'b1;
    req = '0;
    idleAll();
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
    testName = "after reset";
    repeat (3) @(negedge clk);

    testName = "priority from idle";
    driveLink(NORTH, 1'b1, HEAD, 2, 0);
    driveLink(EAST, 1'b1, HEAD, 2, 0);
    driveLink(SOUTH, 1'b1, HEAD, 2, 0);
    @(negedge clk);
    compareValue("lowest requester", 5'b00010, grant);
    idleAll();
    awaitGrant('0, 5);
    for (int p = 0; p < 5; p++)
      driveLink(p, 1'b1, HEAD, 2, 1);
    @(negedge clk);
    compareValue("lowest requester", 5'b00001, grant);
    idleAll();
    awaitGrant('0, 5);

    testName = "timeout and rotation";
    for (int p = 0; p < 5; p++)
      driveLink(p, 1'b1, HEAD, p + 1, 2); // hold of p+2 cycles
    awaitGrant(5'b00001, 4);
    for (int r = 0; r < 2; r++)
    begin
      for (int h = 0; h < 5; h++)
      begin
        compareValue("rotation holder", 5'b00001 << h, grant);
        holdCount = 0;
        while (grant == (5'b00001 << h) && holdCount < 20)
        begin
          holdCount++;
          @(negedge clk);
        end
        compareValue("hold cycles", h + 2, holdCount);
      end
    end
    idleAll();
    awaitGrant('0, 5);

    testName = "lone requester";
    driveLink(WEST, 1'b1, HEAD, 2, 3);
    awaitGrant(5'b01000, 4);
    holdCount = 0;
    while (grant == 5'b01000 && holdCount < 20)
    begin
      holdCount++;
      @(negedge clk);
    end
    compareValue("hold cycles", 3, holdCount);
    compareValue("idle gap", 5'b00000, grant);
    @(negedge clk);
    compareValue("granted again", 5'b01000, grant);
    idleAll();
    awaitGrant('0, 5);

    testName = "early release";
    driveLink(EAST, 1'b1, HEAD, 7, 4);
    driveLink(SOUTH, 1'b1, HEAD, 7, 4);
    awaitGrant(5'b00100, 4);
    @(negedge clk);
    driveLink(EAST, 1'b0, NONE, 0, 5);
    @(negedge clk);
    compareValue("release to next", 5'b10000, grant);
    driveLink(SOUTH, 1'b0, NONE, 0, 5);
    driveLink(LOCAL, 1'b1, HEAD, 7, 5);
    @(negedge clk);
    compareValue("release wraps to local", 5'b00001, grant);
    idleAll();
    @(negedge clk);
    compareValue("release to idle", 5'b00000, grant);

    testName = "random traffic";
    for (int p = 0; p < 5; p++)
    begin
      srcPos[p] = -1;
      srcGap[p] = $urandom % 4;
      srcSeq[p] = 0;
      srcLen[p] = 0;
    end
    lastGrant = '0;
    for (int c = 0; c < RANDOM_CYCLES; c++)
    begin
      @(negedge clk);
      for (int p = 0; p < 5; p++)
        stepSource(p);
      lastGrant = grant; // consumed at the coming edge
    end
    idleAll();
    awaitGrant('0, 10);
    repeat (2) @(negedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/noc_pkg.sv
rtl/flitLink_if.sv
rtl/packetTimer.sv
rtl/outputArbiter.sv
rtl/outputMux.sv
rtl/routerOutputPort.sv
verification/tb_routerOutputPort.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the router output port testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -Wno-fatal -f files.f \
  --top-module tb_routerOutputPort -o simv \
  && ./obj_dir/simv > "$LOG" 2>&1 \
  || echo "build or simulation returned an error status" >> "$LOG"

cat "$LOG"

grep -q "tests failed" "$LOG" && exit 1
grep -q "all tests passed" "$LOG" || exit 1
exit 0
